// File: src/wdma_config.svh
`ifndef WDMA_CONFIG_SVH
`define WDMA_CONFIG_SVH

// ====================
// command fields
// ====================

// address in 8-byte units
`define WDMA_ADDR_W 29
// zero bits appended for the 32-bit byte address
`define WDMA_ADDR_SHIFT 3
// beat count minus one
`define WDMA_SIZE_W 13
// addr + size + cube_end
`define WDMA_CMD_W 43

// ====================
// data path
// ====================

// number of lane fifos
`define WDMA_LANES 4
// one lane word
`define WDMA_LANE_W 64
// write request payload, pkt type in msb
`define WDMA_REQ_W 66

// alu algo code for equality compare
`define WDMA_ALU_EQL 2'd3

`endif

// File: src/wdma_pkg.sv
`default_nettype none

`include "wdma_config.svh"

package wdma_pkg;

  // ====================
  // command side
  // ====================

  // command address, 8-byte granule
  typedef logic [`WDMA_ADDR_W-1:0] addr_t;

  // number of data beats minus one
  typedef logic [`WDMA_SIZE_W-1:0] size_t;

  // raw command from the cmd fifo
  // cube_end at msb, then size, addr in the low bits
  typedef logic [`WDMA_CMD_W-1:0] cmd_pd_t;

  // ====================
  // data side
  // ====================

  // one word popped from a lane fifo
  typedef logic [`WDMA_LANE_W-1:0] lane_data_t;

  // dma write request, cmd or dat packet
  typedef logic [`WDMA_REQ_W-1:0] req_pd_t;

endpackage

`default_nettype wire

// File: src/wdma_cmd_hold.sv
`timescale 1ns/1ns
`default_nettype none

`include "wdma_config.svh"

module wdma_cmd_hold (
  input  wire                    nvdla_core_clk,
  input  wire                    nvdla_core_rstn,
  // command in
  input  wire                    cmd2dat_dma_pvld,
  output logic                   cmd2dat_dma_prdy,
  input  wire wdma_pkg::cmd_pd_t cmd2dat_dma_pd,
  // retire from the beat sequencer
  input  wire                    cmd_done,
  // held command out
  output logic                   cmd_vld,
  output wdma_pkg::addr_t        cmd_addr,
  output wdma_pkg::size_t        cmd_size,
  output logic                   cmd_cube_end
);

  logic cmd_accept;

  // ====================
  // handshake
  // ====================

  // empty slot, or the held one retires this cycle
  // so back-to-back commands need no bubble
  assign cmd2dat_dma_prdy = ~cmd_vld | cmd_done;
  assign cmd_accept       = cmd2dat_dma_pvld & cmd2dat_dma_prdy;

  // holder valid
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cmd_vld <= 1'b0;
    end else if (cmd2dat_dma_prdy) begin
      cmd_vld <= cmd2dat_dma_pvld;
    end
  end

  // ====================
  // payload
  // ====================

  // unpack fields on accept
  always_ff @(posedge nvdla_core_clk) begin
    if (cmd_accept) begin
      cmd_addr     <= cmd2dat_dma_pd[`WDMA_ADDR_W-1:0];
      cmd_size     <= cmd2dat_dma_pd[`WDMA_ADDR_W +: `WDMA_SIZE_W];
      cmd_cube_end <= cmd2dat_dma_pd[`WDMA_CMD_W-1];
    end
  end

  // sequencer must only retire a command that is held here
  a_done_needs_cmd: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    cmd_done |-> cmd_vld
  ) else $error("cmd_done while no command is held");

endmodule

`default_nettype wire

// File: src/wdma_beat_seq.sv
`timescale 1ns/1ns
`default_nettype none

`include "wdma_config.svh"

module wdma_beat_seq (
  input  wire                       nvdla_core_clk,
  input  wire                       nvdla_core_rstn,
  // held command
  input  wire                       cmd_vld,
  input  wire wdma_pkg::addr_t      cmd_addr,
  input  wire wdma_pkg::size_t      cmd_size,
  input  wire                       cmd_cube_end,
  output logic                      cmd_done,
  output logic                      layer_end,
  // lane fifos
  input  wire                       dfifo0_rd_pvld,
  input  wire                       dfifo1_rd_pvld,
  input  wire                       dfifo2_rd_pvld,
  input  wire                       dfifo3_rd_pvld,
  input  wire wdma_pkg::lane_data_t dfifo0_rd_pd,
  input  wire wdma_pkg::lane_data_t dfifo1_rd_pd,
  input  wire wdma_pkg::lane_data_t dfifo2_rd_pd,
  input  wire wdma_pkg::lane_data_t dfifo3_rd_pd,
  output logic                      dfifo0_rd_prdy,
  output logic                      dfifo1_rd_prdy,
  output logic                      dfifo2_rd_prdy,
  output logic                      dfifo3_rd_prdy,
  // write request
  output logic                      dma_wr_req_vld,
  input  wire                       dma_wr_req_rdy,
  output wdma_pkg::req_pd_t         dma_wr_req_pd,
  // mode registers
  input  wire                       reg2dp_ew_bypass,
  input  wire                       reg2dp_ew_alu_bypass,
  input  wire [1:0]                 reg2dp_ew_alu_algo,
  input  wire                       reg2dp_output_dst
);

  localparam int LANE_SEL_W = $clog2(`WDMA_LANES);
  // zero fill between cube_end and the pkt type bit
  localparam int REQ_PAD_W  = `WDMA_REQ_W - 2 - `WDMA_SIZE_W - `WDMA_ADDR_W - `WDMA_ADDR_SHIFT;

  logic                  cfg_mode_quiet;
  logic                  wr_rdy;
  logic                  dat_phase;
  logic                  dat_rdy;
  logic                  dat_accept;
  logic                  cmd_accept;
  logic                  is_last_beat;
  logic                  lane_vld;
  logic [LANE_SEL_W-1:0] lane_sel;
  wdma_pkg::size_t       beat_count;
  wdma_pkg::lane_data_t  lane_pd;

  // ====================
  // mode and readiness
  // ====================

  // eq compare or pdp routing, nothing goes to dma
  assign cfg_mode_quiet = (~reg2dp_ew_bypass & ~reg2dp_ew_alu_bypass &
                           (reg2dp_ew_alu_algo == `WDMA_ALU_EQL)) | reg2dp_output_dst;
  // quiet mode sinks everything
  assign wr_rdy = cfg_mode_quiet | dma_wr_req_rdy;

  assign cmd_accept   = ~dat_phase & cmd_vld & wr_rdy;
  assign dat_rdy      = dat_phase & wr_rdy;
  assign dat_accept   = dat_rdy & lane_vld;
  assign is_last_beat = (beat_count == cmd_size);
  assign cmd_done     = dat_accept & is_last_beat;
  assign layer_end    = cmd_done & cmd_cube_end;

  // cmd pkt first, then size+1 dat pkts
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      dat_phase <= 1'b0;
    end else if (cmd_accept) begin
      dat_phase <= 1'b1;
    end else if (cmd_done) begin
      dat_phase <= 1'b0;
    end
  end

  // beat counter, wraps on the last beat
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      beat_count <= '0;
    end else if (dat_accept) begin
      beat_count <= is_last_beat ? '0 : beat_count + 1'b1;
    end
  end

  // ====================
  // lane select
  // ====================

  // beat k reads lane k mod 4
  assign lane_sel = beat_count[LANE_SEL_W-1:0];

  always_comb begin
    case (lane_sel)
      LANE_SEL_W'(0): begin
        lane_vld = dfifo0_rd_pvld;
        lane_pd  = dfifo0_rd_pd;
      end
      LANE_SEL_W'(1): begin
        lane_vld = dfifo1_rd_pvld;
        lane_pd  = dfifo1_rd_pd;
      end
      LANE_SEL_W'(2): begin
        lane_vld = dfifo2_rd_pvld;
        lane_pd  = dfifo2_rd_pd;
      end
      default: begin
        lane_vld = dfifo3_rd_pvld;
        lane_pd  = dfifo3_rd_pd;
      end
    endcase
  end

  // only the selected lane sees ready
  assign dfifo0_rd_prdy = dat_rdy & (lane_sel == LANE_SEL_W'(0));
  assign dfifo1_rd_prdy = dat_rdy & (lane_sel == LANE_SEL_W'(1));
  assign dfifo2_rd_prdy = dat_rdy & (lane_sel == LANE_SEL_W'(2));
  assign dfifo3_rd_prdy = dat_rdy & (lane_sel == LANE_SEL_W'(3));

  // ====================
  // request packing
  // ====================

  assign dma_wr_req_vld = (dat_phase ? lane_vld : cmd_vld) & ~cfg_mode_quiet;

  always_comb begin
    if (dat_phase) begin
      // dat pkt, single-lane mask
      dma_wr_req_pd = {1'b1, 1'b1, lane_pd};
    end else begin
      // cmd pkt, byte address, size and cube end
      dma_wr_req_pd = {1'b0, {REQ_PAD_W{1'b0}}, cmd_cube_end, cmd_size,
                       cmd_addr, {`WDMA_ADDR_SHIFT{1'b0}}};
    end
  end

  // held size must not move under a running command
  a_beat_in_range: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    dat_phase |-> (beat_count <= cmd_size)
  ) else $error("beat count past command size");

  // stalled request holds, relies on lane fifo heads staying put
  a_req_stable: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (dma_wr_req_vld && !dma_wr_req_rdy) |=> (dma_wr_req_vld && $stable(dma_wr_req_pd))
  ) else $error("write request changed while stalled");

endmodule

`default_nettype wire

// File: src/wdma_status.sv
`timescale 1ns/1ns
`default_nettype none

`include "wdma_config.svh"

module wdma_status (
  input  wire                       nvdla_core_clk,
  input  wire                       nvdla_core_rstn,
  input  wire                       op_load,
  input  wire                       layer_end,
  input  wire                       reg2dp_interrupt_ptr,
  // lane handshakes, watched only
  input  wire                       dfifo0_rd_pvld,
  input  wire                       dfifo1_rd_pvld,
  input  wire                       dfifo2_rd_pvld,
  input  wire                       dfifo3_rd_pvld,
  input  wire                       dfifo0_rd_prdy,
  input  wire                       dfifo1_rd_prdy,
  input  wire                       dfifo2_rd_prdy,
  input  wire                       dfifo3_rd_prdy,
  input  wire wdma_pkg::lane_data_t dfifo0_rd_pd,
  input  wire wdma_pkg::lane_data_t dfifo1_rd_pd,
  input  wire wdma_pkg::lane_data_t dfifo2_rd_pd,
  input  wire wdma_pkg::lane_data_t dfifo3_rd_pd,
  // status and interrupt
  output logic                      dp2reg_status_unequal,
  output logic                      dp2reg_done,
  output logic                      intr_req_pvld,
  output logic                      intr_req_ptr
);

  logic nonzero_pop;

  // ====================
  // unequal tracking
  // ====================

  // any consumed word with a set bit
  assign nonzero_pop = (dfifo0_rd_pvld & dfifo0_rd_prdy & (|dfifo0_rd_pd)) |
                       (dfifo1_rd_pvld & dfifo1_rd_prdy & (|dfifo1_rd_pd)) |
                       (dfifo2_rd_pvld & dfifo2_rd_prdy & (|dfifo2_rd_pd)) |
                       (dfifo3_rd_pvld & dfifo3_rd_prdy & (|dfifo3_rd_pd));

  // sticky until next op_load
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      dp2reg_status_unequal <= 1'b0;
    end else if (op_load) begin
      dp2reg_status_unequal <= 1'b0;
    end else if (nonzero_pop) begin
      dp2reg_status_unequal <= 1'b1;
    end
  end

  // ====================
  // done and interrupt
  // ====================

  // done one cycle behind the last cube beat
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      dp2reg_done <= 1'b0;
    end else begin
      dp2reg_done <= layer_end;
    end
  end

  // intr in the same cycle as the beat
  assign intr_req_pvld = layer_end;
  assign intr_req_ptr  = reg2dp_interrupt_ptr;

  // a cube end needs a cmd pkt and a dat beat in between
  a_done_pulse: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    dp2reg_done |=> !dp2reg_done
  ) else $error("done high in two consecutive cycles");

endmodule

`default_nettype wire

// File: src/wdma_dat_out.sv
`timescale 1ns/1ns
`default_nettype none

`include "wdma_config.svh"

module wdma_dat_out (
  input  wire                       nvdla_core_clk,
  input  wire                       nvdla_core_rstn,
  input  wire                       op_load,
  // command in
  input  wire                       cmd2dat_dma_pvld,
  output logic                      cmd2dat_dma_prdy,
  input  wire wdma_pkg::cmd_pd_t    cmd2dat_dma_pd,
  // lane fifos
  input  wire                       dfifo0_rd_pvld,
  input  wire                       dfifo1_rd_pvld,
  input  wire                       dfifo2_rd_pvld,
  input  wire                       dfifo3_rd_pvld,
  output logic                      dfifo0_rd_prdy,
  output logic                      dfifo1_rd_prdy,
  output logic                      dfifo2_rd_prdy,
  output logic                      dfifo3_rd_prdy,
  input  wire wdma_pkg::lane_data_t dfifo0_rd_pd,
  input  wire wdma_pkg::lane_data_t dfifo1_rd_pd,
  input  wire wdma_pkg::lane_data_t dfifo2_rd_pd,
  input  wire wdma_pkg::lane_data_t dfifo3_rd_pd,
  // dma write request
  output logic                      dma_wr_req_vld,
  input  wire                       dma_wr_req_rdy,
  output wdma_pkg::req_pd_t         dma_wr_req_pd,
  // registers
  input  wire                       reg2dp_ew_bypass,
  input  wire                       reg2dp_ew_alu_bypass,
  input  wire [1:0]                 reg2dp_ew_alu_algo,
  input  wire                       reg2dp_output_dst,
  input  wire                       reg2dp_interrupt_ptr,
  output logic                      dp2reg_status_unequal,
  output logic                      dp2reg_done,
  // interrupt
  output logic                      intr_req_pvld,
  output logic                      intr_req_ptr
);

  // held command
  wire                   cmd_vld;
  wdma_pkg::addr_t       cmd_addr;
  wdma_pkg::size_t       cmd_size;
  wire                   cmd_cube_end;
  // beat sequencer events
  wire                   cmd_done;
  wire                   layer_end;

  // ports match by name throughout
  wdma_cmd_hold u_cmd_hold (.*);

  wdma_beat_seq u_beat_seq (.*);

  wdma_status u_status (.*);

endmodule

`default_nettype wire

// File: verif/tb_wdma_dat_out.sv
`timescale 1ns/1ns
`default_nettype none

module tb_wdma_dat_out;

  // ====================
  // run limits
  // ====================

  // cmd pkts plus data beats, per test in order
  localparam int TOTAL_BEATS    = 11 + 20 + 10 + 10 + 15;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_BEATS;

  // dut inputs
  logic                 nvdla_core_clk  = 1'b0;
  logic                 nvdla_core_rstn = 1'b0;
  logic                 op_load         = 1'b0;
  logic                 cmd_pvld        = 1'b0;
  wdma_pkg::cmd_pd_t    cmd_pd          = '0;
  logic [3:0]           lane_pvld       = '0;
  wdma_pkg::lane_data_t lane_pd [4]     = '{default: '0};
  logic                 wr_rdy          = 1'b0;
  logic                 ew_bypass       = 1'b1;
  logic                 alu_bypass      = 1'b1;
  logic [1:0]           alu_algo        = 2'd0;
  logic                 output_dst      = 1'b0;
  logic                 intr_ptr_reg    = 1'b0;

  // dut outputs
  wire                    cmd_prdy;
  wire [3:0]              lane_prdy;
  wire                    wr_vld;
  wire wdma_pkg::req_pd_t wr_pd;
  wire                    unequal;
  wire                    done;
  wire                    intr_pvld;
  wire                    intr_ptr;

  // lane fifo contents, sink log and expected stream
  wdma_pkg::lane_data_t lane_q [4][$];
  wdma_pkg::req_pd_t    got_q[$];
  wdma_pkg::req_pd_t    exp_q[$];
  wdma_pkg::cmd_pd_t    cmd_list[$];

  logic [31:0]          lfsr_state = 32'h5361_2f14;
  // sparse lane valids, random request ready, quiet mode with sink ready low
  logic                 sparse     = 1'b0;
  logic                 stall_rdy  = 1'b0;
  logic                 quiet_exp  = 1'b0;
  logic                 stall_prev = 1'b0;
  wdma_pkg::req_pd_t    stall_pd   = '0;
  logic                 intr_prev  = 1'b0;
  int                   done_cnt   = 0;
  int                   intr_cnt   = 0;
  int                   exp_done   = 0;
  int                   word_seq   = 0;
  int                   cycle_cnt  = 0;
  int                   error_cnt  = 0;

  wdma_dat_out u_wdma_dat_out (
    .nvdla_core_clk        (nvdla_core_clk),
    .nvdla_core_rstn       (nvdla_core_rstn),
    .op_load               (op_load),
    .cmd2dat_dma_pvld      (cmd_pvld),
    .cmd2dat_dma_prdy      (cmd_prdy),
    .cmd2dat_dma_pd        (cmd_pd),
    .dfifo0_rd_pvld        (lane_pvld[0]),
    .dfifo1_rd_pvld        (lane_pvld[1]),
    .dfifo2_rd_pvld        (lane_pvld[2]),
    .dfifo3_rd_pvld        (lane_pvld[3]),
    .dfifo0_rd_prdy        (lane_prdy[0]),
    .dfifo1_rd_prdy        (lane_prdy[1]),
    .dfifo2_rd_prdy        (lane_prdy[2]),
    .dfifo3_rd_prdy        (lane_prdy[3]),
    .dfifo0_rd_pd          (lane_pd[0]),
    .dfifo1_rd_pd          (lane_pd[1]),
    .dfifo2_rd_pd          (lane_pd[2]),
    .dfifo3_rd_pd          (lane_pd[3]),
    .dma_wr_req_vld        (wr_vld),
    .dma_wr_req_rdy        (wr_rdy),
    .dma_wr_req_pd         (wr_pd),
    .reg2dp_ew_bypass      (ew_bypass),
    .reg2dp_ew_alu_bypass  (alu_bypass),
    .reg2dp_ew_alu_algo    (alu_algo),
    .reg2dp_output_dst     (output_dst),
    .reg2dp_interrupt_ptr  (intr_ptr_reg),
    .dp2reg_status_unequal (unequal),
    .dp2reg_done           (done),
    .intr_req_pvld         (intr_pvld),
    .intr_req_ptr          (intr_ptr)
  );

  initial begin
    forever #50 nvdla_core_clk = ~nvdla_core_clk;
  end

  // ====================
  // helpers
  // ====================

  // 32-bit fibonacci lfsr, taps 32 22 2 1
  function automatic logic next_rand_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic lanes_busy();
    return (lane_q[0].size() + lane_q[1].size() + lane_q[2].size() + lane_q[3].size()) != 0;
  endfunction

  task automatic check_eq(input logic [65:0] got, input logic [65:0] exp, input string what);
    if (got !== exp) begin
      error_cnt++;
      $display("Mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "stopping at first error");
    end
  endtask

  // lane fifos, sink and interrupt monitor
  always @(posedge nvdla_core_clk) begin
    logic gate;
    if (nvdla_core_rstn) begin
      // stalled request must hold
      if (stall_prev) begin
        check_eq(66'(wr_vld), 66'(1), "request valid dropped while stalled");
        check_eq(wr_pd, stall_pd, "request payload changed while stalled");
      end
      if (quiet_exp) begin
        check_eq(66'(wr_vld), 66'(0), "request raised in quiet mode");
      end
      if (wr_vld && wr_rdy) begin
        got_q.push_back(wr_pd);
      end
      stall_prev = wr_vld && !wr_rdy;
      stall_pd   = wr_pd;
      // intr ptr checked on the pulse, done one cycle behind
      if (intr_pvld) begin
        intr_cnt++;
        check_eq(66'(intr_ptr), 66'(intr_ptr_reg), "interrupt pointer");
      end
      check_eq(66'(done), 66'(intr_prev), "done not one cycle after interrupt");
      if (done) begin
        done_cnt++;
      end
      intr_prev = intr_pvld;
      // a shown valid stays until popped
      for (int i = 0; i < 4; i++) begin
        if (lane_pvld[i] && lane_prdy[i]) begin
          void'(lane_q[i].pop_front());
        end
        if (!lane_pvld[i] || lane_prdy[i]) begin
          gate = sparse ? next_rand_bit() : 1'b1;
          lane_pvld[i] <= gate && (lane_q[i].size() != 0);
          lane_pd[i]   <= (lane_q[i].size() != 0) ? lane_q[i][0] : '0;
        end
      end
      // quiet mode must drain without any ready from the sink
      wr_rdy <= quiet_exp ? 1'b0 : (stall_rdy ? next_rand_bit() : 1'b1);
    end
  end

  always @(posedge nvdla_core_clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $fatal(1, "timeout");
    end
  end

  // lane words and expected packets of one command
  // kind 0 patterned, 1 all zero, 2 zero except beat 1
  task automatic add_cmd(input wdma_pkg::addr_t addr, input wdma_pkg::size_t size,
                         input logic cube, input int kind, input logic quiet);
    wdma_pkg::lane_data_t w;
    wdma_pkg::req_pd_t    p;
    // cmd pkt, byte address in the low 32 bits
    p        = '0;
    p[31:0]  = {addr, 3'b000};
    p[44:32] = size;
    p[45]    = cube;
    if (!quiet) begin
      exp_q.push_back(p);
    end
    for (int k = 0; k <= int'(size); k++) begin
      word_seq++;
      w = {16'hd1a0, word_seq[15:0], 32'h5a5a_0f0f ^ 32'(k)};
      if (kind == 1 || (kind == 2 && k != 1)) begin
        w = '0;
      end
      lane_q[k % 4].push_back(w);
      if (!quiet) begin
        exp_q.push_back({2'b11, w});
      end
    end
    cmd_list.push_back({cube, size, addr});
    if (cube) begin
      exp_done++;
    end
  endtask

  // send queued commands back to back, then wait for the stream to drain
  task automatic issue_and_wait();
    @(posedge nvdla_core_clk);
    while (cmd_list.size() != 0) begin
      cmd_pvld <= 1'b1;
      cmd_pd   <= cmd_list.pop_front();
      @(posedge nvdla_core_clk);
      while (!cmd_prdy) begin
        @(posedge nvdla_core_clk);
      end
    end
    cmd_pvld <= 1'b0;
    @(negedge nvdla_core_clk);
    while (got_q.size() < exp_q.size() || done_cnt < exp_done || lanes_busy()) begin
      @(negedge nvdla_core_clk);
    end
    repeat (3) @(negedge nvdla_core_clk);
    check_eq(66'(got_q.size()), 66'(exp_q.size()), "accepted packet count");
    check_eq(66'(done_cnt), 66'(exp_done), "done pulse count");
    check_eq(66'(intr_cnt), 66'(exp_done), "interrupt count");
    for (int i = 0; i < exp_q.size(); i++) begin
      check_eq(got_q[i], exp_q[i], $sformatf("packet %0d", i));
    end
    got_q.delete();
    exp_q.delete();
  endtask

  task automatic set_mode(input logic ew, input logic alu, input logic [1:0] algo,
                          input logic dst, input logic quiet);
    @(posedge nvdla_core_clk);
    ew_bypass  <= ew;
    alu_bypass <= alu;
    alu_algo   <= algo;
    output_dst <= dst;
    @(negedge nvdla_core_clk);
    quiet_exp = quiet;
  endtask

  task automatic pulse_op_load();
    @(posedge nvdla_core_clk);
    op_load <= 1'b1;
    @(posedge nvdla_core_clk);
    op_load <= 1'b0;
    @(negedge nvdla_core_clk);
  endtask

  // ====================
  // directed tests
  // ====================

  task automatic test_free_flow();
    @(negedge nvdla_core_clk);
    add_cmd(29'h0abc_1234, 13'd9, 1'b1, 0, 1'b0);
    issue_and_wait();
  endtask

  task automatic test_backpressure();
    @(negedge nvdla_core_clk);
    sparse    = 1'b1;
    stall_rdy = 1'b1;
    add_cmd(29'h1000_0040, 13'd5, 1'b0, 0, 1'b0);
    add_cmd(29'h1000_0100, 13'd2, 1'b0, 0, 1'b0);
    add_cmd(29'h1fff_fff8, 13'd7, 1'b1, 0, 1'b0);
    issue_and_wait();
    sparse    = 1'b0;
    stall_rdy = 1'b0;
  endtask

  task automatic test_quiet();
    // equality compare
    set_mode(1'b0, 1'b0, 2'd3, 1'b0, 1'b1);
    add_cmd(29'h0000_2000, 13'd3, 1'b1, 0, 1'b1);
    issue_and_wait();
    // routed to pooling
    set_mode(1'b1, 1'b1, 2'd0, 1'b1, 1'b1);
    add_cmd(29'h0000_3000, 13'd3, 1'b1, 0, 1'b1);
    issue_and_wait();
    set_mode(1'b1, 1'b1, 2'd0, 1'b0, 1'b0);
  endtask

  task automatic test_done_intr();
    @(posedge nvdla_core_clk);
    intr_ptr_reg <= 1'b1;
    @(negedge nvdla_core_clk);
    add_cmd(29'h0200_0000, 13'd1, 1'b1, 0, 1'b0);
    add_cmd(29'h0200_0010, 13'd2, 1'b0, 0, 1'b0);
    add_cmd(29'h0200_0020, 13'd1, 1'b1, 0, 1'b0);
    issue_and_wait();
    @(posedge nvdla_core_clk);
    intr_ptr_reg <= 1'b0;
  endtask

  task automatic test_unequal();
    pulse_op_load();
    check_eq(66'(unequal), 66'(0), "unequal after op_load");
    add_cmd(29'h0300_0000, 13'd3, 1'b0, 1, 1'b0);
    issue_and_wait();
    check_eq(66'(unequal), 66'(0), "unequal after all-zero words");
    add_cmd(29'h0300_0040, 13'd3, 1'b0, 2, 1'b0);
    issue_and_wait();
    check_eq(66'(unequal), 66'(1), "unequal after one nonzero word");
    add_cmd(29'h0300_0080, 13'd3, 1'b1, 1, 1'b0);
    issue_and_wait();
    check_eq(66'(unequal), 66'(1), "unequal not sticky");
    pulse_op_load();
    check_eq(66'(unequal), 66'(0), "unequal not cleared by op_load");
  endtask

  initial begin
    repeat (4) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    test_free_flow();
    test_backpressure();
    test_quiet();
    test_done_intr();
    test_unequal();
    @(negedge nvdla_core_clk);
    if (error_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+src
src/wdma_pkg.sv
src/wdma_cmd_hold.sv
src/wdma_beat_seq.sv
src/wdma_status.sv
src/wdma_dat_out.sv
verif/tb_wdma_dat_out.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, then look for the pass line in the log
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_wdma_dat_out -o sim_wdma_dat_out &&
./obj_dir/sim_wdma_dat_out > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q -F '*** PASSED ***' sim.log && echo "run ok" || { echo "run failed"; exit 1; }
